//--- hw/fetch_pkg.sv
package fetch_pkg;

    ////////////////////
    // widths and sizes
    ////////////////////

    localparam int XLEN       = 32;                 // data and address width.
    localparam int TAG_W      = 3;                  // flow tag, wraps past 7.
    localparam int IMEM_DEPTH = 256;                // words.
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH); // word index width.
    localparam int APB_AW     = 12;

    localparam logic [XLEN-1:0] BOOT_RESET = 32'h0000_0000;

    ////////////////////
    // register map
    ////////////////////

    localparam logic [APB_AW-1:0] CTRL_OFS   = 12'h000;
    localparam logic [APB_AW-1:0] BOOT_OFS   = 12'h004;
    localparam logic [APB_AW-1:0] MTVEC_OFS  = 12'h008;
    localparam logic [APB_AW-1:0] MEPC_OFS   = 12'h00C;
    localparam logic [APB_AW-1:0] STATUS_OFS = 12'h010; // read only.
    localparam logic [APB_AW-1:0] IMEM_BASE  = 12'h400; // window up to 0x7fc.

    localparam int CTRL_RUN_BIT  = 0;
    localparam int CTRL_SRST_BIT = 1; // self-clearing.

    typedef enum logic [2:0] {
        SEL_CTRL,
        SEL_BOOT,
        SEL_MTVEC,
        SEL_MEPC,
        SEL_STATUS,
        SEL_IMEM,
        SEL_NONE
    } csr_sel_e;

endpackage

//--- hw/fetch_cfg_if.sv
`timescale 1ns/1ps

interface fetch_cfg_if;

    logic                       run;        // fetch enable.
    logic                       soft_reset; // one-cycle pulse.
    logic [fetch_pkg::XLEN-1:0] boot_addr;
    logic [fetch_pkg::XLEN-1:0] mtvec;      // trap vector.
    logic [fetch_pkg::XLEN-1:0] mepc;       // return pc.
    logic [fetch_pkg::XLEN-1:0] cur_pc;     // status readback.

    // register side.
    modport csr (
        output run, soft_reset, boot_addr, mtvec, mepc,
        input  cur_pc
    );

    // pipeline side.
    modport fetch (
        input  run, soft_reset, boot_addr, mtvec, mepc,
        output cur_pc
    );

endinterface

//--- hw/fetch_csr_apb.sv
`timescale 1ns/1ps

module fetch_csr_apb (
    input  logic                          clk_i,
    input  logic                          reset_n,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [fetch_pkg::APB_AW-1:0]  paddr_i,
    input  logic [fetch_pkg::XLEN-1:0]    pwdata_i,
    output logic [fetch_pkg::XLEN-1:0]    prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    fetch_cfg_if.csr                      cfg,
    output logic                          imem_we_o,
    output logic [fetch_pkg::IMEM_AW-1:0] imem_waddr_o,
    output logic [fetch_pkg::XLEN-1:0]    imem_wdata_o
);

    fetch_pkg::csr_sel_e sel;

    logic                       access;
    logic                       wr_en;
    logic                       run_q;
    logic                       soft_reset_q;
    logic [fetch_pkg::XLEN-1:0] boot_q;
    logic [fetch_pkg::XLEN-1:0] mtvec_q;
    logic [fetch_pkg::XLEN-1:0] mepc_q;

    ////////////////////
    // address decode
    ////////////////////

    always_comb begin
        if (paddr_i[1:0] != 2'b00) begin
            sel = fetch_pkg::SEL_NONE; // unaligned.
        end else if (paddr_i[fetch_pkg::APB_AW-1:fetch_pkg::IMEM_AW+2] ==
                     fetch_pkg::IMEM_BASE[fetch_pkg::APB_AW-1:fetch_pkg::IMEM_AW+2]) begin
            sel = fetch_pkg::SEL_IMEM;
        end else begin
            case (paddr_i)
                fetch_pkg::CTRL_OFS:   sel = fetch_pkg::SEL_CTRL;
                fetch_pkg::BOOT_OFS:   sel = fetch_pkg::SEL_BOOT;
                fetch_pkg::MTVEC_OFS:  sel = fetch_pkg::SEL_MTVEC;
                fetch_pkg::MEPC_OFS:   sel = fetch_pkg::SEL_MEPC;
                fetch_pkg::STATUS_OFS: sel = fetch_pkg::SEL_STATUS;
                default:               sel = fetch_pkg::SEL_NONE;
            endcase
        end
    end

    assign access   = psel_i & penable_i;      // no wait states.
    assign wr_en    = access & pwrite_i;
    assign pready_o = 1'b1;

    assign pslverr_o = access & ((sel == fetch_pkg::SEL_NONE) |
                                 (!pwrite_i & (sel == fetch_pkg::SEL_IMEM)) |
                                 (pwrite_i & (sel == fetch_pkg::SEL_STATUS)));

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            run_q        <= 1'b0;
            soft_reset_q <= 1'b0;
            boot_q       <= fetch_pkg::BOOT_RESET;
            mtvec_q      <= '0;
            mepc_q       <= '0;
        end else begin
            soft_reset_q <= 1'b0; // pulse drops after one cycle.
            if (wr_en) begin
                case (sel)
                    fetch_pkg::SEL_CTRL: begin
                        run_q        <= pwdata_i[fetch_pkg::CTRL_RUN_BIT];
                        soft_reset_q <= pwdata_i[fetch_pkg::CTRL_SRST_BIT];
                    end
                    fetch_pkg::SEL_BOOT:  boot_q  <= pwdata_i;
                    fetch_pkg::SEL_MTVEC: mtvec_q <= pwdata_i;
                    fetch_pkg::SEL_MEPC:  mepc_q  <= pwdata_i;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (sel)
            fetch_pkg::SEL_CTRL: begin
                prdata_o[fetch_pkg::CTRL_RUN_BIT]  = run_q;
                prdata_o[fetch_pkg::CTRL_SRST_BIT] = soft_reset_q;
            end
            fetch_pkg::SEL_BOOT:   prdata_o = boot_q;
            fetch_pkg::SEL_MTVEC:  prdata_o = mtvec_q;
            fetch_pkg::SEL_MEPC:   prdata_o = mepc_q;
            fetch_pkg::SEL_STATUS: prdata_o = cfg.cur_pc;
            default:               prdata_o = '0;
        endcase
    end

    assign cfg.run        = run_q;
    assign cfg.soft_reset = soft_reset_q;
    assign cfg.boot_addr  = boot_q;
    assign cfg.mtvec      = mtvec_q;
    assign cfg.mepc       = mepc_q;

    // memory window writes pass straight through.
    assign imem_we_o    = wr_en & (sel == fetch_pkg::SEL_IMEM);
    assign imem_waddr_o = paddr_i[fetch_pkg::IMEM_AW+1:2];
    assign imem_wdata_o = pwdata_i;

    a_pready: assert property (@(posedge clk_i) disable iff (!reset_n)
        psel_i && penable_i |-> pready_o)
        else $error("pready low in access phase");

    a_srst_pulse: assert property (@(posedge clk_i) disable iff (!reset_n)
        cfg.soft_reset |=> !cfg.soft_reset)
        else $error("soft reset longer than one cycle");

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                          clk,
    input  logic                          reset_n,
    fetch_cfg_if.fetch                    cfg,
    input  logic                          mret_i,
    input  logic                          exception_i,
    input  logic                          interrupt_ack_i,
    input  logic                          jump_i,
    input  logic [fetch_pkg::XLEN-1:0]    jump_target_i,
    input  logic                          hazard_i,
    output logic [fetch_pkg::IMEM_AW-1:0] imem_raddr_o,
    input  logic [fetch_pkg::XLEN-1:0]    imem_rdata_i,
    output logic [fetch_pkg::XLEN-1:0]    instr_o,
    output logic [fetch_pkg::XLEN-1:0]    pc_o,
    output logic [fetch_pkg::TAG_W-1:0]   tag_o,
    output logic                          instr_valid_o,
    output logic                          jumped_o,
    output logic                          jump_misaligned_o
);

    logic [fetch_pkg::XLEN-1:0]  pc;
    logic [fetch_pkg::XLEN-1:0]  redir_target;
    logic [fetch_pkg::TAG_W-1:0] cur_tag;
    logic [fetch_pkg::TAG_W-1:0] next_tag;
    logic                        pc_jumped;     // pc came from a redirect.
    logic                        pc_misaligned;
    logic                        trap;
    logic                        tag_step;
    logic                        redirect;
    logic                        advance;

    ////////////////////
    // pc control
    ////////////////////

    assign trap     = exception_i | interrupt_ack_i;
    assign tag_step = mret_i | trap | jump_i;       // soft reset keeps the tag.
    assign redirect = tag_step | cfg.soft_reset;
    assign advance  = cfg.run & ~hazard_i & ~redirect;

    // fixed priority: mret, trap, jump, then soft reset.
    always_comb begin
        if (mret_i) begin
            redir_target = cfg.mepc;
        end else if (trap) begin
            redir_target = cfg.mtvec;
        end else if (jump_i) begin
            redir_target = jump_target_i;
        end else begin
            redir_target = cfg.boot_addr;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc            <= fetch_pkg::BOOT_RESET;
            pc_jumped     <= 1'b0;
            pc_misaligned <= 1'b0;
        end else if (redirect) begin
            pc            <= redir_target;
            pc_jumped     <= 1'b1;
            pc_misaligned <= |redir_target[1:0];
        end else if (advance) begin
            pc            <= {pc[fetch_pkg::XLEN-1:2], 2'b00} + fetch_pkg::XLEN'(4); // realign.
            pc_jumped     <= 1'b0;
            pc_misaligned <= 1'b0;
        end
    end

    assign cfg.cur_pc = pc;

    ////////////////////
    // tag calculator
    ////////////////////

    assign next_tag = cur_tag + fetch_pkg::TAG_W'(1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cur_tag <= '0;
        end else if (tag_step) begin
            cur_tag <= next_tag;
        end
    end

    ////////////////////
    // fetch outputs
    ////////////////////

    // a stall re-reads the word on display so instr_o holds with pc_o.
    assign imem_raddr_o = hazard_i ? pc_o[fetch_pkg::IMEM_AW+1:2]
                                   : pc[fetch_pkg::IMEM_AW+1:2];
    assign instr_o      = imem_rdata_i; // memory read register is the output stage.

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_valid_o     <= 1'b0;
            pc_o              <= '0;
            tag_o             <= '0;
            jumped_o          <= 1'b0;
            jump_misaligned_o <= 1'b0;
        end else if (redirect) begin
            instr_valid_o     <= 1'b0;  // squash old path.
            jumped_o          <= 1'b0;
            jump_misaligned_o <= 1'b0;
        end else if (!hazard_i) begin
            instr_valid_o     <= cfg.run;
            if (cfg.run) begin
                pc_o              <= pc;
                tag_o             <= cur_tag;
                jumped_o          <= pc_jumped;
                jump_misaligned_o <= pc_misaligned;
            end
        end
    end

    a_squash: assert property (@(posedge clk) disable iff (!reset_n)
        redirect |=> !instr_valid_o)
        else $error("valid word right after redirect");

    a_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        instr_valid_o && !jump_misaligned_o |-> pc_o[1:0] == 2'b00)
        else $error("unaligned pc without misalignment flag");

endmodule

//--- hw/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
    input  logic                          clk,
    input  logic [fetch_pkg::IMEM_AW-1:0] raddr_i,
    output logic [fetch_pkg::XLEN-1:0]    rdata_o,
    input  logic                          we_i,
    input  logic [fetch_pkg::IMEM_AW-1:0] waddr_i,
    input  logic [fetch_pkg::XLEN-1:0]    wdata_i
);

    logic [fetch_pkg::XLEN-1:0] mem [fetch_pkg::IMEM_DEPTH];

    ////////////////////
    // apb write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    ////////////////////
    // fetch read port
    ////////////////////

    // same-word collision returns the old contents.
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i]; // one cycle latency.
    end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [fetch_pkg::APB_AW-1:0] paddr_i,
    input  logic [fetch_pkg::XLEN-1:0]   pwdata_i,
    output logic [fetch_pkg::XLEN-1:0]   prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  logic                         mret_i,
    input  logic                         exception_i,
    input  logic                         interrupt_ack_i,
    input  logic                         jump_i,
    input  logic [fetch_pkg::XLEN-1:0]   jump_target_i,
    input  logic                         hazard_i,
    output logic [fetch_pkg::XLEN-1:0]   instr_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_o,
    output logic [fetch_pkg::TAG_W-1:0]  tag_o,
    output logic                         instr_valid_o,
    output logic                         jumped_o,
    output logic                         jump_misaligned_o
);

    logic [fetch_pkg::IMEM_AW-1:0] imem_raddr;
    logic [fetch_pkg::XLEN-1:0]    imem_rdata;
    logic                          imem_we;
    logic [fetch_pkg::IMEM_AW-1:0] imem_waddr;
    logic [fetch_pkg::XLEN-1:0]    imem_wdata;

    fetch_cfg_if cfg_if ();

    fetch_csr_apb csr0 (
        .clk_i        (clk),
        .reset_n      (reset_n),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .cfg          (cfg_if.csr),
        .imem_we_o    (imem_we),
        .imem_waddr_o (imem_waddr),
        .imem_wdata_o (imem_wdata)
    );

    fetch_unit fetch0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .cfg               (cfg_if.fetch),
        .mret_i            (mret_i),
        .exception_i       (exception_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .jump_i            (jump_i),
        .jump_target_i     (jump_target_i),
        .hazard_i          (hazard_i),
        .imem_raddr_o      (imem_raddr),
        .imem_rdata_i      (imem_rdata),
        .instr_o           (instr_o),
        .pc_o              (pc_o),
        .tag_o             (tag_o),
        .instr_valid_o     (instr_valid_o),
        .jumped_o          (jumped_o),
        .jump_misaligned_o (jump_misaligned_o)
    );

    instr_mem imem0 (
        .clk     (clk),
        .raddr_i (imem_raddr),
        .rdata_o (imem_rdata),
        .we_i    (imem_we),
        .waddr_i (imem_waddr),
        .wdata_i (imem_wdata)
    );

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int          MAX_CYCLES = 4000;         // tests need about 900 cycles.
    localparam logic [31:0] SEED       = 32'hb05e_f42d;

    logic                               clk;
    logic                               reset_n;
    logic                               psel_i;
    logic                               penable_i;
    logic                               pwrite_i;
    logic [fetch_pkg::APB_AW-1:0]       paddr_i;
    logic [fetch_pkg::XLEN-1:0]         pwdata_i;
    logic [fetch_pkg::XLEN-1:0]         prdata_o;
    logic                               pready_o;
    logic                               pslverr_o;
    logic                               mret_i;
    logic                               exception_i;
    logic                               interrupt_ack_i;
    logic                               jump_i;
    logic [fetch_pkg::XLEN-1:0]         jump_target_i;
    logic                               hazard_i;
    logic [fetch_pkg::XLEN-1:0]         instr_o;
    logic [fetch_pkg::XLEN-1:0]         pc_o;
    logic [fetch_pkg::TAG_W-1:0]        tag_o;
    logic                               instr_valid_o;
    logic                               jumped_o;
    logic                               jump_misaligned_o;

    // reference model state.
    logic [fetch_pkg::XLEN-1:0]  m_mem [fetch_pkg::IMEM_DEPTH];
    logic [fetch_pkg::XLEN-1:0]  m_pc;
    logic [fetch_pkg::XLEN-1:0]  m_boot;
    logic [fetch_pkg::XLEN-1:0]  m_mtvec;
    logic [fetch_pkg::XLEN-1:0]  m_mepc;
    logic [fetch_pkg::TAG_W-1:0] m_tag;
    logic                        m_run;
    logic                        m_srst;
    logic                        m_pc_jumped;
    logic                        m_pc_mis;
    logic                        e_valid;
    logic                        e_jumped;
    logic                        e_mis;
    logic [fetch_pkg::XLEN-1:0]  e_pc;
    logic [fetch_pkg::XLEN-1:0]  e_instr;
    logic [fetch_pkg::TAG_W-1:0] e_tag;
    logic                        any_redirect;
    logic                        tag_advance;
    logic [fetch_pkg::XLEN-1:0]  redirect_to;
    logic [fetch_pkg::XLEN-1:0]  fill_key;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int errs_at_start;
    int cycles       = 0;
    int valid_words  = 0;
    int words_before;

    fetch_top dut0 (.*);

    always #4 clk = ~clk;

    ////////////////////
    // reference model
    ////////////////////

    assign tag_advance  = mret_i | exception_i | interrupt_ack_i | jump_i;
    assign any_redirect = tag_advance | m_srst;
    assign e_instr      = m_mem[e_pc[fetch_pkg::IMEM_AW+1:2]];

    always_comb begin
        if (mret_i) begin
            redirect_to = m_mepc;
        end else if (exception_i || interrupt_ack_i) begin
            redirect_to = m_mtvec;
        end else if (jump_i) begin
            redirect_to = jump_target_i;
        end else begin
            redirect_to = m_boot;   // soft reset.
        end
    end

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            m_pc        <= fetch_pkg::BOOT_RESET;
            m_boot      <= fetch_pkg::BOOT_RESET;
            m_mtvec     <= '0;
            m_mepc      <= '0;
            m_tag       <= '0;
            m_run       <= 1'b0;
            m_srst      <= 1'b0;
            m_pc_jumped <= 1'b0;
            m_pc_mis    <= 1'b0;
            e_valid     <= 1'b0;
            e_jumped    <= 1'b0;
            e_mis       <= 1'b0;
            e_pc        <= '0;
            e_tag       <= '0;
        end else begin
            m_srst <= 1'b0;
            if (instr_valid_o) begin
                valid_words <= valid_words + 1;
            end
            if (psel_i && penable_i && pwrite_i) begin
                if (paddr_i >= fetch_pkg::IMEM_BASE && paddr_i < 12'h800) begin
                    m_mem[paddr_i[fetch_pkg::IMEM_AW+1:2]] <= pwdata_i;
                end else begin
                    case (paddr_i)
                        fetch_pkg::CTRL_OFS: begin
                            m_run  <= pwdata_i[0];
                            m_srst <= pwdata_i[1];
                        end
                        fetch_pkg::BOOT_OFS:  m_boot  <= pwdata_i;
                        fetch_pkg::MTVEC_OFS: m_mtvec <= pwdata_i;
                        fetch_pkg::MEPC_OFS:  m_mepc  <= pwdata_i;
                        default: ;
                    endcase
                end
            end
            if (any_redirect) begin
                m_pc        <= redirect_to;
                m_pc_jumped <= 1'b1;
                m_pc_mis    <= redirect_to[1:0] != 2'b00;
                e_valid     <= 1'b0;  // old word squashed.
                e_jumped    <= 1'b0;
                e_mis       <= 1'b0;
                if (tag_advance) begin
                    m_tag <= m_tag + 3'd1;
                end
            end else if (!hazard_i) begin
                e_valid <= m_run;
                if (m_run) begin
                    m_pc        <= {m_pc[31:2], 2'b00} + 32'd4;
                    m_pc_jumped <= 1'b0;
                    m_pc_mis    <= 1'b0;
                    e_pc        <= m_pc;
                    e_tag       <= m_tag;
                    e_jumped    <= m_pc_jumped;
                    e_mis       <= m_pc_mis;
                end
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
    endtask

    a_valid: assert property (@(posedge clk) disable iff (!reset_n)
        instr_valid_o == e_valid)
        else report_mismatch("instr_valid_o", 32'($sampled(e_valid)),
                             32'($sampled(instr_valid_o)));

    a_pc: assert property (@(posedge clk) disable iff (!reset_n)
        e_valid |-> pc_o == e_pc)
        else report_mismatch("pc_o", $sampled(e_pc), $sampled(pc_o));

    a_instr: assert property (@(posedge clk) disable iff (!reset_n)
        e_valid |-> instr_o == e_instr)
        else report_mismatch("instr_o", $sampled(e_instr), $sampled(instr_o));

    a_tag: assert property (@(posedge clk) disable iff (!reset_n)
        e_valid |-> tag_o == e_tag)
        else report_mismatch("tag_o", 32'($sampled(e_tag)), 32'($sampled(tag_o)));

    a_jumped: assert property (@(posedge clk) disable iff (!reset_n)
        e_valid |-> jumped_o == e_jumped)
        else report_mismatch("jumped_o", 32'($sampled(e_jumped)),
                             32'($sampled(jumped_o)));

    a_misaligned: assert property (@(posedge clk) disable iff (!reset_n)
        e_valid |-> jump_misaligned_o == e_mis)
        else report_mismatch("jump_misaligned_o", 32'($sampled(e_mis)),
                             32'($sampled(jump_misaligned_o)));

    a_pready: assert property (@(posedge clk) disable iff (!reset_n)
        psel_i && penable_i |-> pready_o)
        else report_mismatch("pready_o", 32'd1, 32'($sampled(pready_o)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////
    // apb and helpers
    ////////////////////

    // called 1 ns after a rising edge, returns at the same point.
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #1;
        penable_i = 1'b1;
        #2;
        rdata = prdata_o;  // mid access phase.
        err   = pslverr_o;
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rdata, err);
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        assert (rdata == exp) else report_mismatch("prdata_o", exp, rdata);
        assert (!err) else report_mismatch("pslverr_o", 32'd0, 32'(err));
    endtask

    task automatic check_err(input logic wr, input logic [11:0] addr, input logic exp);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(wr, addr, 32'h5a5a_5a5a, rdata, err);
        assert (err == exp) else report_mismatch("pslverr_o", 32'(exp), 32'(err));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errs_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_at_start);
        end else begin
            $display("test %s: ok", name);
        end
        errs_at_start = errors;
    endtask

    task automatic pulse_redirect(input int kind, input logic [31:0] target);
        jump_target_i = target;
        case (kind)
            0: jump_i = 1'b1;
            1: exception_i = 1'b1;
            2: interrupt_ack_i = 1'b1;
            3: mret_i = 1'b1;
            4: begin
                jump_i      = 1'b1;
                exception_i = 1'b1;
            end
            default: begin
                mret_i          = 1'b1;   // all at once, with a stall.
                interrupt_ack_i = 1'b1;
                jump_i          = 1'b1;
                hazard_i        = 1'b1;
            end
        endcase
        wait_cycles(1);
        mret_i          = 1'b0;
        exception_i     = 1'b0;
        interrupt_ack_i = 1'b0;
        jump_i          = 1'b0;
        hazard_i        = 1'b0;
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        mret_i          = 1'b0;
        exception_i     = 1'b0;
        interrupt_ack_i = 1'b0;
        jump_i          = 1'b0;
        jump_target_i   = '0;
        hazard_i        = 1'b0;
        void'($urandom(SEED));
        fill_key      = $urandom();
        errs_at_start = 0;
        wait_cycles(10);
        reset_n = 1'b1;
        wait_cycles(1);

        check_read(fetch_pkg::BOOT_OFS, fetch_pkg::BOOT_RESET);
        apb_write(fetch_pkg::BOOT_OFS, 32'h0000_0040);
        apb_write(fetch_pkg::MTVEC_OFS, 32'h0000_01f0);
        apb_write(fetch_pkg::MEPC_OFS, 32'h0000_02a4);
        check_read(fetch_pkg::BOOT_OFS, 32'h0000_0040);
        check_read(fetch_pkg::MTVEC_OFS, 32'h0000_01f0);
        check_read(fetch_pkg::MEPC_OFS, 32'h0000_02a4);
        pulse_redirect(0, 32'h0000_0124);
        check_read(fetch_pkg::STATUS_OFS, 32'h0000_0124); // pc loaded by the jump.
        check_err(1'b0, 12'h020, 1'b1);            // unmapped.
        check_err(1'b1, 12'h3f0, 1'b1);
        check_err(1'b0, 12'h404, 1'b1);            // memory window read.
        check_err(1'b1, fetch_pkg::STATUS_OFS, 1'b1);
        check_err(1'b0, fetch_pkg::MEPC_OFS, 1'b0);
        finish_test("register access");

        for (int i = 0; i < fetch_pkg::IMEM_DEPTH; i++) begin
            apb_write(fetch_pkg::IMEM_BASE + 12'(i * 4), i * 32'h0101_0101 ^ fill_key);
        end
        words_before = valid_words;
        apb_write(fetch_pkg::CTRL_OFS, 32'h1);
        wait_cycles(32);
        assert (valid_words - words_before > 25)
            else begin
                errors++;
                $display("fetch produced too few valid words after run was set");
            end
        finish_test("sequential fetch");

        for (int i = 0; i < 48; i++) begin
            hazard_i = ($urandom_range(0, 2) == 0);
            wait_cycles(1);
        end
        hazard_i = 1'b0;
        wait_cycles(4);
        finish_test("hazard stall");

        // twelve redirects take the tag past 7.
        for (int k = 0; k < 12; k++) begin
            pulse_redirect(k % 6, {22'd0, 8'($urandom_range(0, 255)), 2'b00});
            wait_cycles($urandom_range(2, 5));
        end
        finish_test("redirects");

        for (int lo = 1; lo < 4; lo++) begin
            pulse_redirect(0, {22'd0, 8'($urandom_range(0, 255)), 2'(lo)});
            wait_cycles(4);
        end
        finish_test("misalignment");

        apb_write(fetch_pkg::CTRL_OFS, 32'h0);
        wait_cycles(6);
        apb_write(fetch_pkg::CTRL_OFS, 32'h3);    // run plus soft reset.
        wait_cycles(12);
        finish_test("run and soft reset");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- build.f
hw/fetch_pkg.sv
hw/fetch_cfg_if.sv
hw/fetch_csr_apb.sv
hw/fetch_unit.sv
hw/instr_mem.sv
hw/fetch_top.sv
verification/fetch_tb.sv
